//--- Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_biquad
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with $(SIM), run it and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- biquad_chk.sv
`timescale 1ns/1ps

module biquad_chk #(
	parameter int DEPTH = 4
) (
	input logic                clk,
	input logic                nreset,
	// buffer write strobe and fill level
	input logic                wr_i,
	input biquad_pkg::credit_t level_i,
	// beat or credit leaving the buffer, and what backs it
	input logic                send_i,
	input biquad_pkg::credit_t backing_i
);
	import biquad_pkg::*;

	localparam credit_t FULL = credit_t'(DEPTH);

	// a write must always find a free slot
	no_write_when_full: assert property (@(posedge clk) disable iff (!nreset)
		wr_i |-> (level_i != FULL))
		else $error("buffer written while full");

	// nothing leaves without a credit or a stored sample behind it
	no_send_without_backing: assert property (@(posedge clk) disable iff (!nreset)
		send_i |-> (backing_i != '0))
		else $error("send with nothing to back it");

	quiet_in_reset: assert property (@(posedge clk) !nreset |-> !send_i)
		else $error("send pulse during reset");

endmodule

//--- biquad_coef_regs.sv
`timescale 1ns/1ps
`include "biquad_config.svh"

module biquad_coef_regs (
	input  logic                  clk,
	input  logic                  nreset,
	input  biquad_pkg::bus_req_t  bus_i,
	output logic                  bus_ack_o,
	output biquad_pkg::bus_word_t bus_rdata_o,
	output biquad_pkg::coef_set_t coefs_o
);
	import biquad_pkg::*;

	localparam int N_COEF = 5;

	// full 16-bit words, readback returns all bits
	bus_word_t  coef_q [N_COEF];
	coef_addr_e sel;

	assign sel = coef_addr_e'(bus_i.adr);

	// zero-wait bus, ack with the strobe
	assign bus_ack_o = bus_i.stb;

	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			for (int i = 0; i < N_COEF; i++)
				coef_q[i] <= '0;
		end
		else if (bus_i.stb && bus_i.we)
		begin
			// addresses 5 to 7 fall through and are dropped
			case (sel)
				A11, A12, B10, B11, B12: coef_q[sel] <= bus_i.wdat;
				default: ;
			endcase
		end
	end

	// read mux, unmapped addresses give zero
	always_comb
	begin
		case (sel)
			A11, A12, B10, B11, B12: bus_rdata_o = coef_q[sel];
			default: bus_rdata_o = '0;
		endcase
	end

	// filter only sees the msbs of each word
	assign coefs_o.a11 = coef_q[A11][`BIQUAD_BUS_W-1 -: `BIQUAD_COEF_W];
	assign coefs_o.a12 = coef_q[A12][`BIQUAD_BUS_W-1 -: `BIQUAD_COEF_W];
	assign coefs_o.b10 = coef_q[B10][`BIQUAD_BUS_W-1 -: `BIQUAD_COEF_W];
	assign coefs_o.b11 = coef_q[B11][`BIQUAD_BUS_W-1 -: `BIQUAD_COEF_W];
	assign coefs_o.b12 = coef_q[B12][`BIQUAD_BUS_W-1 -: `BIQUAD_COEF_W];

endmodule

//--- biquad_config.svh
`ifndef BIQUAD_CONFIG_SVH
`define BIQUAD_CONFIG_SVH

// sample width, signed integer samples
`define BIQUAD_DATA_W 8
// coefficient width seen by the filter
// top bits of each register word
`define BIQUAD_COEF_W 8
// headroom bits on the internal state
`define BIQUAD_GUARD_W 2

// register word and address widths
`define BIQUAD_BUS_W 16
`define BIQUAD_ADDR_W 3

// input buffer slots, also the upstream credits after reset
`define BIQUAD_IN_DEPTH 4
// result buffer slots, also the core credits after reset
`define BIQUAD_OUT_DEPTH 4
// credit counters must hold the largest depth
`define BIQUAD_CREDIT_W 3

`endif

//--- biquad_core.sv
`timescale 1ns/1ps
`include "biquad_config.svh"

module biquad_core (
	input  logic                     clk,
	input  logic                     nreset,
	input  biquad_pkg::coef_set_t    coefs_i,
	input  biquad_pkg::sample_beat_t head_i,
	output logic                     pop_o,
	input  logic                     free_credit_i,
	output biquad_pkg::sample_beat_t result_o
);
	import biquad_pkg::*;

	localparam int STATE_W = $bits(state_t);
	// coefficients are q1.(COEF_W-1) fractions
	localparam int FRAC_W = `BIQUAD_COEF_W - 1;
	localparam acc_t S_MAX = acc_t'((1 << (STATE_W - 1)) - 1);
	localparam acc_t S_MIN = acc_t'(-(1 << (STATE_W - 1)));
	localparam state_t Y_MAX = state_t'((1 << (`BIQUAD_DATA_W - 1)) - 1);
	localparam state_t Y_MIN = state_t'(-(1 << (`BIQUAD_DATA_W - 1)));

	credit_t res_credit_q;
	// valid flags down the pipe
	logic    v1_q;
	logic    v2_q;
	logic    res_v_q;
	// x[n], x[n-1], x[n-2]
	sample_t x0_q;
	sample_t xm1_q;
	sample_t xm2_q;
	// s[n-1], s[n-2]
	state_t  s1_q;
	state_t  s2_q;
	acc_t    p_b10;
	acc_t    p_b11;
	acc_t    p_b12;
	acc_t    p_a11;
	acc_t    p_a12;
	acc_t    ff_d;
	acc_t    ff_q;
	acc_t    acc_d;
	acc_t    acc_sh;
	state_t  s_d;
	sample_t y_d;
	sample_t y_q;

	// pop only with room reserved in the result buffer
	assign pop_o = head_i.valid && (res_credit_q != '0);

	always_comb
	begin
		// products widen to acc_t through the assignment
		p_b10 = coefs_i.b10 * x0_q;
		p_b11 = coefs_i.b11 * xm1_q;
		p_b12 = coefs_i.b12 * xm2_q;
		ff_d  = p_b10 + p_b11 + p_b12;
		// feedback uses the state the previous sample just wrote
		p_a11 = coefs_i.a11 * s1_q;
		p_a12 = coefs_i.a12 * s2_q;
		acc_d = ff_q + p_a11 + p_a12;
		// floor division by 2^FRAC_W
		acc_sh = acc_d >>> FRAC_W;
		if (acc_sh > S_MAX)
			s_d = state_t'(S_MAX);
		else if (acc_sh < S_MIN)
			s_d = state_t'(S_MIN);
		else
			s_d = state_t'(acc_sh);
		// second clamp down to sample range
		if (s_d > Y_MAX)
			y_d = sample_t'(Y_MAX);
		else if (s_d < Y_MIN)
			y_d = sample_t'(Y_MIN);
		else
			y_d = sample_t'(s_d);
	end

	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			res_credit_q <= credit_t'(`BIQUAD_OUT_DEPTH);
			v1_q    <= 1'b0;
			v2_q    <= 1'b0;
			res_v_q <= 1'b0;
			x0_q    <= '0;
			xm1_q   <= '0;
			xm2_q   <= '0;
			s1_q    <= '0;
			s2_q    <= '0;
		end
		else
		begin
			res_credit_q <= res_credit_q - credit_t'(pop_o) + credit_t'(free_credit_i);
			v1_q    <= pop_o;
			v2_q    <= v1_q;
			res_v_q <= v2_q;
			// shift input history on capture
			if (pop_o)
			begin
				x0_q  <= head_i.data;
				xm1_q <= x0_q;
				xm2_q <= xm1_q;
			end
			// state history moves once per finished sample
			if (v2_q)
			begin
				s1_q <= s_d;
				s2_q <= s1_q;
			end
		end
	end

	// datapath payload
	always_ff @(posedge clk)
	begin
		if (v1_q)
			ff_q <= ff_d;
		if (v2_q)
			y_q <= y_d;
	end

	assign result_o.valid = res_v_q;
	assign result_o.data  = y_q;

endmodule

//--- biquad_pkg.sv
`include "biquad_config.svh"

package biquad_pkg;

	// widths that carry a meaning
	typedef logic signed [`BIQUAD_DATA_W-1:0] sample_t;
	typedef logic signed [`BIQUAD_COEF_W-1:0] coef_t;
	// state keeps guard bits above the sample range
	typedef logic signed [`BIQUAD_DATA_W+`BIQUAD_GUARD_W-1:0] state_t;
	// exact sum of five products
	typedef logic signed [`BIQUAD_DATA_W+`BIQUAD_GUARD_W+`BIQUAD_COEF_W+2:0] acc_t;
	typedef logic [`BIQUAD_BUS_W-1:0] bus_word_t;
	typedef logic [`BIQUAD_ADDR_W-1:0] bus_addr_t;
	typedef logic [`BIQUAD_CREDIT_W-1:0] credit_t;

	// register map
	typedef enum logic [`BIQUAD_ADDR_W-1:0] {
		A11 = 3'd0,
		A12 = 3'd1,
		B10 = 3'd2,
		B11 = 3'd3,
		B12 = 3'd4
	} coef_addr_e;

	typedef struct packed {
		coef_t a11;
		coef_t a12;
		coef_t b10;
		coef_t b11;
		coef_t b12;
	} coef_set_t;

	typedef struct packed {
		logic      stb;
		logic      we;
		bus_addr_t adr;
		bus_word_t wdat;
	} bus_req_t;

	typedef struct packed {
		logic    valid;
		sample_t data;
	} sample_beat_t;

endpackage

//--- biquad_top.sv
`timescale 1ns/1ps

module biquad_top (
	input  logic                     clk,
	input  logic                     nreset,
	input  biquad_pkg::bus_req_t     bus_i,
	output logic                     bus_ack_o,
	output biquad_pkg::bus_word_t    bus_rdata_o,
	input  biquad_pkg::sample_beat_t in_i,
	output logic                     in_credit_o,
	output biquad_pkg::sample_beat_t out_o,
	input  logic                     out_credit_i
);
	import biquad_pkg::*;

	coef_set_t    coefs;
	sample_beat_t head;
	logic         pop;
	sample_beat_t result;
	// one pulse per result slot drained downstream
	logic         free_credit;

	// coefficient registers on the bus
	biquad_coef_regs coef_regs_i (
		.clk         (clk),
		.nreset      (nreset),
		.bus_i       (bus_i),
		.bus_ack_o   (bus_ack_o),
		.bus_rdata_o (bus_rdata_o),
		.coefs_o     (coefs)
	);

	// input buffer, credits back to the sender
	sample_ingress ingress_i (
		.clk         (clk),
		.nreset      (nreset),
		.in_i        (in_i),
		.pop_i       (pop),
		.head_o      (head),
		.in_credit_o (in_credit_o)
	);

	// filter datapath, pops against result credits
	biquad_core core_i (
		.clk           (clk),
		.nreset        (nreset),
		.coefs_i       (coefs),
		.head_i        (head),
		.pop_o         (pop),
		.free_credit_i (free_credit),
		.result_o      (result)
	);

	// result buffer, sends against downstream credits
	sample_egress egress_i (
		.clk           (clk),
		.nreset        (nreset),
		.result_i      (result),
		.out_credit_i  (out_credit_i),
		.out_o         (out_o),
		.free_credit_o (free_credit)
	);

endmodule

//--- flist.f
+incdir+.
biquad_pkg.sv
biquad_coef_regs.sv
sample_ingress.sv
biquad_core.sv
sample_egress.sv
biquad_top.sv
biquad_chk.sv
tb_biquad.sv

//--- sample_egress.sv
`timescale 1ns/1ps
`include "biquad_config.svh"

module sample_egress (
	input  logic                     clk,
	input  logic                     nreset,
	input  biquad_pkg::sample_beat_t result_i,
	input  logic                     out_credit_i,
	output biquad_pkg::sample_beat_t out_o,
	output logic                     free_credit_o
);
	import biquad_pkg::*;

	localparam int DEPTH = `BIQUAD_OUT_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	sample_t          mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	credit_t          count_q;
	// downstream grants not yet used
	credit_t          dn_credit_q;
	logic             send;

	// send the head while a held credit remains
	// credit arriving this cycle counts from the next one
	assign send = (count_q != '0) && (dn_credit_q != '0);

	assign out_o.valid = send;
	assign out_o.data  = mem_q[rd_ptr_q];

	// slot leaves with the beat, give it back to the core
	assign free_credit_o = send;

	// core only writes against a reserved slot
	always_ff @(posedge clk)
	begin
		if (result_i.valid)
			mem_q[wr_ptr_q] <= result_i.data;
	end

	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			dn_credit_q <= '0;
		end
		else
		begin
			if (result_i.valid)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (send)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			count_q <= count_q + credit_t'(result_i.valid) - credit_t'(send);
			// grant and spend may coincide
			dn_credit_q <= dn_credit_q + credit_t'(out_credit_i) - credit_t'(send);
		end
	end

endmodule

//--- sample_ingress.sv
`timescale 1ns/1ps
`include "biquad_config.svh"

module sample_ingress (
	input  logic                     clk,
	input  logic                     nreset,
	input  biquad_pkg::sample_beat_t in_i,
	input  logic                     pop_i,
	output biquad_pkg::sample_beat_t head_o,
	output logic                     in_credit_o
);
	import biquad_pkg::*;

	localparam int DEPTH = `BIQUAD_IN_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	sample_t          mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	credit_t          count_q;
	logic             pop;

	// sender owns the credits, so a write never lands on a full buffer
	assign head_o.valid = (count_q != '0);
	assign head_o.data  = mem_q[rd_ptr_q];

	// only a real pop frees a slot
	assign pop = pop_i && head_o.valid;
	// one credit back upstream per slot freed
	assign in_credit_o = pop;

	always_ff @(posedge clk)
	begin
		if (in_i.valid)
			mem_q[wr_ptr_q] <= in_i.data;
	end

	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (in_i.valid)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			// push and pop in one cycle leave the count alone
			count_q <= count_q + credit_t'(in_i.valid) - credit_t'(pop);
		end
	end

endmodule

//--- tb_biquad.sv
`timescale 1ns/1ps
`include "biquad_config.svh"

module tb_biquad;
	import biquad_pkg::*;

	localparam int HALF_PERIOD = 4;
	localparam int FRAC_W = `BIQUAD_COEF_W - 1;
	localparam int STATE_W = `BIQUAD_DATA_W + `BIQUAD_GUARD_W;
	localparam int Y_MAX = (1 << (`BIQUAD_DATA_W - 1)) - 1;
	// pass-through, random, saturation, back-pressure
	localparam int TOTAL_SAMPLES = 16 + 200 + 32 + 60;
	localparam int MARGIN_CYCLES = 2000;

	logic         clk;
	logic         nreset;
	bus_req_t     bus;
	logic         bus_ack;
	bus_word_t    bus_rdata;
	sample_beat_t in_beat;
	logic         in_credit;
	sample_beat_t out_beat;
	logic         out_credit;

	logic [31:0] lfsr;
	string       test_name;
	// samples still to send, expected outputs in order
	int          stim_q [$];
	int          exp_q [$];
	int          coef_val [5];
	// model history x[n-1], x[n-2], s[n-1], s[n-2]
	int          x1;
	int          x2;
	int          s1;
	int          s2;
	int          in_credits;
	int          sent;
	int          returned;
	int          granted;
	int          received;
	logic        hit_max;
	logic        hit_min;
	logic        starved;

	biquad_top dut_i (
		.clk          (clk),
		.nreset       (nreset),
		.bus_i        (bus),
		.bus_ack_o    (bus_ack),
		.bus_rdata_o  (bus_rdata),
		.in_i         (in_beat),
		.in_credit_o  (in_credit),
		.out_o        (out_beat),
		.out_credit_i (out_credit)
	);

	// credit returned only when a stored sample leaves
	bind sample_ingress biquad_chk #(.DEPTH(`BIQUAD_IN_DEPTH)) ingress_chk_i (
		.clk       (clk),
		.nreset    (nreset),
		.wr_i      (in_i.valid),
		.level_i   (count_q),
		.send_i    (in_credit_o),
		.backing_i (count_q)
	);

	// beat sent only against a held downstream credit
	bind sample_egress biquad_chk #(.DEPTH(`BIQUAD_OUT_DEPTH)) egress_chk_i (
		.clk       (clk),
		.nreset    (nreset),
		.wr_i      (result_i.valid),
		.level_i   (count_q),
		.send_i    (out_o.valid),
		.backing_i (dn_credit_q)
	);

	always #HALF_PERIOD clk = ~clk;

	// galois lfsr, one step per bit taken
	function automatic int rand_bits(input int n);
		int   v;
		logic lsb;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 32'h8020_0003;
			v = (v << 1) | int'(lsb);
		end
		return v;
	endfunction

	function automatic int clamp(input longint v, input int bits);
		longint hi;
		longint lo;
		hi = (longint'(1) << (bits - 1)) - 1;
		lo = -hi - 1;
		if (v > hi)
			return int'(hi);
		if (v < lo)
			return int'(lo);
		return int'(v);
	endfunction

	// one step of the biquad rule on the model history
	function automatic int model_step(input int x);
		longint acc;
		int     s;
		acc = longint'(coef_val[B10]) * x + longint'(coef_val[B11]) * x1
			+ longint'(coef_val[B12]) * x2 + longint'(coef_val[A11]) * s1
			+ longint'(coef_val[A12]) * s2;
		// signed shift floors toward minus infinity
		s = clamp(acc >>> FRAC_W, STATE_W);
		x2 = x1;
		x1 = x;
		s2 = s1;
		s1 = s;
		return clamp(s, `BIQUAD_DATA_W);
	endfunction

	// distinct word per register
	function automatic int reg_pattern(input int a);
		return 'h9a31 + a * 'h1011;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual)
			abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
				name, expected, actual));
	endtask

	// one strobe cycle, ack checked with and after the strobe
	task automatic bus_access(input logic write, input int adr, input bus_word_t wdat,
		output bus_word_t rdat);
		@(posedge clk);
		bus <= '{stb: 1'b1, we: write, adr: bus_addr_t'(adr), wdat: wdat};
		@(negedge clk);
		check_value("bus ack with strobe", 1, int'(bus_ack));
		rdat = bus_rdata;
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
		check_value("bus ack after strobe", 0, int'(bus_ack));
	endtask

	task automatic set_coef(input int adr, input bus_word_t w);
		bus_word_t unused;
		bus_access(1'b1, adr, w, unused);
		// filter sees only the top bits
		coef_val[adr] = int'($signed(w[`BIQUAD_BUS_W-1 -: `BIQUAD_COEF_W]));
	endtask

	// send the queued samples and wait until all came back
	task automatic stream(input string name, input logic sparse);
		int   x;
		logic grant;
		test_name = name;
		while (stim_q.size() != 0 || received != sent)
		begin
			@(posedge clk);
			grant = 1'b0;
			// outstanding grants stay within the 3-bit counter
			if (granted - received < 4)
				grant = sparse ? (rand_bits(3) == 0) : (rand_bits(1) == 1);
			out_credit <= grant;
			granted += int'(grant);
			if (stim_q.size() != 0 && in_credits == 0)
				starved = 1'b1;
			if (stim_q.size() != 0 && in_credits != 0)
			begin
				x = stim_q.pop_front();
				in_beat <= '{valid: 1'b1, data: sample_t'(x)};
				exp_q.push_back(model_step(x));
				in_credits--;
				sent++;
			end
			else
				in_beat.valid <= 1'b0;
		end
		@(posedge clk);
		out_credit <= 1'b0;
	endtask

	// compare outputs and count returned input credits
	always @(negedge clk)
	begin
		if (nreset && out_beat.valid)
		begin
			if (exp_q.size() == 0)
				abort_run("an output appeared with no sample pending");
			else
				check_value(test_name, exp_q.pop_front(), int'(out_beat.data));
			received++;
			if (received > granted)
				abort_run("more outputs than downstream credits granted");
			if (int'(out_beat.data) == Y_MAX)
				hit_max = 1'b1;
			if (int'(out_beat.data) == -Y_MAX - 1)
				hit_min = 1'b1;
		end
		if (nreset && in_credit)
		begin
			returned++;
			in_credits++;
			if (sent - returned < 0 || sent - returned > `BIQUAD_IN_DEPTH)
				abort_run("input credits out of range");
		end
	end

	initial
	begin
		#(2 * HALF_PERIOD * (40 * TOTAL_SAMPLES + MARGIN_CYCLES));
		abort_run("watchdog expired before all samples came back");
	end

	initial
	begin
		bus_word_t rd;
		clk = 1'b0;
		nreset = 1'b0;
		bus = '0;
		in_beat = '0;
		out_credit = 1'b0;
		lfsr = 32'h18bd_b4e4;
		in_credits = `BIQUAD_IN_DEPTH;
		sent = 0;
		returned = 0;
		granted = 0;
		received = 0;
		x1 = 0;
		x2 = 0;
		s1 = 0;
		s2 = 0;
		starved = 1'b0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		nreset <= 1'b1;
		@(negedge clk);
		check_value("outputs quiet after reset", 0, int'(in_credit | out_beat.valid | bus_ack));

		// mapped words, then writes to 5..7 that must vanish
		for (int a = 0; a < 5; a++)
			bus_access(1'b1, a, bus_word_t'(reg_pattern(a)), rd);
		for (int a = 5; a < 8; a++)
			bus_access(1'b1, a, 16'hffff, rd);
		for (int a = 0; a < 8; a++)
		begin
			bus_access(1'b0, a, '0, rd);
			check_value($sformatf("register %0d readback", a),
				(a < 5) ? reg_pattern(a) : 0, int'(rd));
		end

		// b10 of 127/128 alone
		set_coef(A11, '0);
		set_coef(A12, '0);
		set_coef(B10, 16'h7f00);
		set_coef(B11, '0);
		set_coef(B12, '0);
		for (int i = 0; i < 16; i++)
			stim_q.push_back(rand_bits(8) - 128);
		stream("pass-through", 1'b0);

		for (int a = 0; a < 5; a++)
			set_coef(a, bus_word_t'(rand_bits(16)));
		for (int i = 0; i < 200; i++)
			stim_q.push_back(rand_bits(8) - 128);
		stream("random filtering", 1'b0);

		// feedback sum above one pushes the state into both clamps
		set_coef(A11, 16'h7e00);
		set_coef(A12, 16'h0400);
		set_coef(B10, 16'h7f00);
		set_coef(B11, '0);
		set_coef(B12, '0);
		hit_max = 1'b0;
		hit_min = 1'b0;
		for (int i = 0; i < 32; i++)
			stim_q.push_back((i < 16) ? Y_MAX : -Y_MAX - 1);
		stream("saturation", 1'b0);
		check_value("saturation reached upper clamp", 1, int'(hit_max));
		check_value("saturation reached lower clamp", 1, int'(hit_min));

		// sparse grants fill every buffer back to the sender
		for (int a = 0; a < 5; a++)
			set_coef(a, bus_word_t'(rand_bits(16)));
		starved = 1'b0;
		for (int i = 0; i < 60; i++)
			stim_q.push_back(rand_bits(8) - 128);
		stream("back-pressure", 1'b1);
		check_value("sender ran out of credits", 1, int'(starved));

		repeat (4) @(posedge clk);
		check_value("input credits returned", sent, returned);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
